// ==== Bender.yml ====
package:
  name: matrix_calc

sources:
  - common/matrix_pkg.sv
  - uart/uart_rx.sv
  - uart/uart_tx.sv
  - source/matrix_parser.sv
  - source/matrix_generator.sv
  - source/matrix_store.sv
  - source/matrix_printer.sv
  - source/matrix_top.sv
  - target: simulation
    files:
      - verification/matrix_assertions.sv
      - verification/tb_matrix_top.sv

// ==== common/matrix_pkg.sv ====
/*
 * matrix_pkg
 * sizes, element and slot types, the matrix record and the
 * character codes shared by the entry, store and print blocks
 */
`default_nettype none

package matrix_pkg;

	// ========================================
	// sizes
	// ========================================
	localparam int DIM_MAX   = 5;  // max rows or cols
	localparam int ELEM_MAX  = 9;  // one decimal digit per element
	localparam int NUM_SLOTS = 2;  // storage slots
	localparam int NUM_ELEMS = DIM_MAX * DIM_MAX;

	typedef logic [2:0] dim_t;
	typedef logic [7:0] elem_t;  // unsigned element
	typedef logic [$clog2(NUM_SLOTS)-1:0] slot_t;
	typedef logic [$clog2(NUM_ELEMS)-1:0] idx_t;  // flat element index

	// row r col c sits at index r*cols+c
	// entries past rows*cols stay zero
	typedef struct packed {
		dim_t                  rows;
		dim_t                  cols;
		elem_t [NUM_ELEMS-1:0] elems;
	} matrix_t;

	// ========================================
	// character codes
	// ========================================
	localparam logic [7:0] ASCII_ZERO  = 8'h30;
	localparam logic [7:0] ASCII_SPACE = 8'h20;
	localparam logic [7:0] ASCII_CR    = 8'h0D;
	localparam logic [7:0] ASCII_LF    = 8'h0A;

	localparam logic [15:0] LFSR_SEED = 16'hACE1;  // generator start state

endpackage

`default_nettype wire

// ==== project.f ====
common/matrix_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
source/matrix_parser.sv
source/matrix_generator.sv
source/matrix_store.sv
source/matrix_printer.sv
source/matrix_top.sv
verification/matrix_assertions.sv
verification/tb_matrix_top.sv

// ==== source/matrix_generator.sv ====
/*
 * matrix_generator
 * takes rows and cols digits in generate mode, then fills one
 * element per clock from a 16 bit Fibonacci LFSR, modulo 10
 */
`default_nettype none

module matrix_generator (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                enable,
	input  logic                rx_done,
	input  logic [7:0]          rx_data,
	output matrix_pkg::matrix_t generated,
	output logic                gen_ready,
	output logic                gen_error
);
	import matrix_pkg::*;

	typedef enum logic [1:0] {G_ROWS, G_COLS, G_FILL} gen_state_t;

	gen_state_t  state;
	logic [15:0] lfsr, lfsr_next;
	idx_t        idx, last_idx;
	logic [7:0]  digit_val;
	logic        is_digit, dim_ok;
	idx_t        dim_prod;

	// taps 15 13 12 10, shifting left
	assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	assign digit_val = rx_data - ASCII_ZERO;
	assign is_digit  = (rx_data >= ASCII_ZERO) && (digit_val <= 8'(ELEM_MAX));
	assign dim_ok    = (digit_val >= 8'd1) && (digit_val <= 8'(DIM_MAX));
	assign dim_prod  = idx_t'(generated.rows) * idx_t'(digit_val[2:0]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= G_ROWS;
			lfsr      <= LFSR_SEED;  // kept across generations
			idx       <= '0;
			last_idx  <= '0;
			generated <= '0;
			gen_ready <= 1'b0;
			gen_error <= 1'b0;
		end else begin
			gen_ready <= 1'b0;
			gen_error <= 1'b0;
			if (!enable) begin
				state <= G_ROWS;  // abort on mode exit
			end else begin
				case (state)
					G_ROWS: if (rx_done && is_digit) begin  // non digits ignored
						if (dim_ok) begin
							generated.rows <= dim_t'(digit_val);
							state          <= G_COLS;
						end else
							gen_error <= 1'b1;
					end
					G_COLS: if (rx_done && is_digit) begin
						if (dim_ok) begin
							generated.cols  <= dim_t'(digit_val);
							generated.elems <= '0;
							idx             <= '0;
							last_idx        <= dim_prod - 1'b1;
							state           <= G_FILL;
						end else begin
							gen_error <= 1'b1;
							state     <= G_ROWS;
						end
					end
					default: begin  // G_FILL, step first then take low byte mod 10
						lfsr                 <= lfsr_next;
						generated.elems[idx] <= elem_t'(lfsr_next[7:0] % (ELEM_MAX + 1));
						if (idx == last_idx) begin
							gen_ready <= 1'b1;
							state     <= G_ROWS;
						end else
							idx <= idx + 1'b1;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/matrix_parser.sv ====
/*
 * matrix_parser
 * builds a matrix from ASCII digits in input mode
 * rows digit, cols digit, then rows*cols element digits
 */
`default_nettype none

module matrix_parser (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                enable,
	input  logic                rx_done,
	input  logic [7:0]          rx_data,
	output matrix_pkg::matrix_t parsed,
	output logic                parse_ready,
	output logic                parse_error
);
	import matrix_pkg::*;

	typedef enum logic [1:0] {P_ROWS, P_COLS, P_ELEMS} parse_state_t;

	parse_state_t state;
	idx_t         idx, last_idx;
	logic [7:0]   digit_val;
	logic         is_digit, is_space, dim_ok;
	idx_t         dim_prod;

	assign digit_val = rx_data - ASCII_ZERO;
	assign is_digit  = (rx_data >= ASCII_ZERO) && (digit_val <= 8'(ELEM_MAX));
	assign is_space  = (rx_data == ASCII_SPACE) || (rx_data == ASCII_CR) ||
	                   (rx_data == ASCII_LF);
	assign dim_ok    = (digit_val >= 8'd1) && (digit_val <= 8'(DIM_MAX));
	assign dim_prod  = idx_t'(parsed.rows) * idx_t'(digit_val[2:0]);  // element count

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= P_ROWS;
			idx         <= '0;
			last_idx    <= '0;
			parsed      <= '0;
			parse_ready <= 1'b0;
			parse_error <= 1'b0;
		end else begin
			parse_ready <= 1'b0;
			parse_error <= 1'b0;
			if (!enable) begin
				state <= P_ROWS;  // leaving input mode drops a partial entry
			end else if (rx_done && !is_space) begin
				if (!is_digit) begin
					parse_error <= 1'b1;  // stray character
					state       <= P_ROWS;
				end else begin
					case (state)
						P_ROWS: begin
							if (dim_ok) begin
								parsed.rows <= dim_t'(digit_val);
								state       <= P_COLS;
							end else
								parse_error <= 1'b1;  // stay and wait for a new rows digit
						end
						P_COLS: begin
							if (dim_ok) begin
								parsed.cols  <= dim_t'(digit_val);
								parsed.elems <= '0;
								idx          <= '0;
								last_idx     <= dim_prod - 1'b1;
								state        <= P_ELEMS;
							end else begin
								parse_error <= 1'b1;
								state       <= P_ROWS;
							end
						end
						default: begin  // P_ELEMS
							parsed.elems[idx] <= elem_t'(digit_val);
							if (idx == last_idx) begin
								parse_ready <= 1'b1;  // last element lands with the pulse
								state       <= P_ROWS;
							end else
								idx <= idx + 1'b1;
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/matrix_printer.sv ====
/*
 * matrix_printer
 * sends one matrix as ASCII rows, digits separated by spaces,
 * each row closed by CR LF, one byte per transmitter idle
 */
`default_nettype none

module matrix_printer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                print_start,
	input  matrix_pkg::matrix_t print_matrix,
	input  logic                tx_busy,
	output logic                print_busy,
	output logic                print_done,
	output logic                tx_start,
	output logic [7:0]          tx_data
);
	import matrix_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_GAP} pr_state_t;
	typedef enum logic [1:0] {K_DIGIT, K_SPACE, K_CR, K_LF} char_kind_t;

	pr_state_t  state;
	char_kind_t kind;  // next character to send
	dim_t       row, col;
	idx_t       idx;
	logic       last;  // final LF already issued
	logic       send;
	logic [7:0] next_char;

	assign send       = (state == S_WAIT) && !tx_busy;
	assign print_busy = (state != S_IDLE);

	always_comb begin
		case (kind)
			K_DIGIT: next_char = ASCII_ZERO + print_matrix.elems[idx];
			K_SPACE: next_char = ASCII_SPACE;
			K_CR:    next_char = ASCII_CR;
			default: next_char = ASCII_LF;
		endcase
	end

	always_ff @(posedge clk) begin
		if (send)
			tx_data <= next_char;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			kind       <= K_DIGIT;
			row        <= '0;
			col        <= '0;
			idx        <= '0;
			last       <= 1'b0;
			tx_start   <= 1'b0;
			print_done <= 1'b0;
		end else begin
			tx_start   <= 1'b0;
			print_done <= 1'b0;
			case (state)
				S_IDLE: if (print_start) begin
					kind  <= K_DIGIT;
					row   <= '0;
					col   <= '0;
					idx   <= '0;
					last  <= 1'b0;
					state <= S_WAIT;
				end
				S_WAIT: if (send) begin
					tx_start <= 1'b1;
					state    <= S_GAP;
					case (kind)
						K_DIGIT: begin
							idx  <= idx + 1'b1;
							kind <= (col == print_matrix.cols - 1'b1) ? K_CR : K_SPACE;
						end
						K_SPACE: begin
							col  <= col + 1'b1;
							kind <= K_DIGIT;
						end
						K_CR: kind <= K_LF;
						default: begin  // K_LF
							if (row == print_matrix.rows - 1'b1)
								last <= 1'b1;
							else begin
								row  <= row + 1'b1;
								col  <= '0;
								kind <= K_DIGIT;
							end
						end
					endcase
				end
				default: begin  // S_GAP lets tx_busy rise
					if (last) begin
						print_done <= 1'b1;
						state      <= S_IDLE;
					end else
						state <= S_WAIT;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/matrix_store.sv ====
/*
 * matrix_store
 * two slot matrix memory fed by either entry path, keeps slot valid
 * flags and the error flag, queues echo and button prints
 */
`default_nettype none

module matrix_store (
	input  logic                clk,
	input  logic                rst_n,
	input  matrix_pkg::matrix_t parsed,
	input  matrix_pkg::matrix_t generated,
	input  logic                parse_ready,
	input  logic                gen_ready,
	input  logic                parse_error,
	input  logic                gen_error,
	input  logic                btn_confirm,
	input  matrix_pkg::slot_t   req_slot,
	input  logic                print_busy,
	input  logic                print_done,
	output logic                print_start,
	output matrix_pkg::matrix_t print_matrix,
	output logic [7:0]          led
);
	import matrix_pkg::*;

	matrix_t              slots [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] slot_valid;
	slot_t                wr_ptr, last_slot, btn_slot, rd_slot;
	logic                 wr_en, issue;
	logic                 echo_pend, btn_pend, in_flight, err_flag;

	assign wr_en   = parse_ready | gen_ready;
	assign rd_slot = echo_pend ? last_slot : btn_slot;  // echo served first
	assign issue   = (echo_pend | btn_pend) & ~in_flight & ~print_busy;

	// ========================================
	// slot memory and print latch
	// ========================================
	always_ff @(posedge clk) begin
		if (wr_en)
			slots[wr_ptr] <= parse_ready ? parsed : generated;
		if (issue)
			print_matrix <= slots[rd_slot];  // held until the next issue
	end

	// ========================================
	// pointers, flags and print queue
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr      <= '0;
			last_slot   <= '0;
			slot_valid  <= '0;
			echo_pend   <= 1'b0;
			btn_pend    <= 1'b0;
			btn_slot    <= '0;
			in_flight   <= 1'b0;
			print_start <= 1'b0;
			err_flag    <= 1'b0;
		end else begin
			print_start <= issue;
			if (issue) begin
				in_flight <= 1'b1;  // blocks reissue until print_done
				if (echo_pend)
					echo_pend <= 1'b0;
				else
					btn_pend <= 1'b0;
			end else if (print_done)
				in_flight <= 1'b0;
			// new requests override the clears above
			if (wr_en) begin
				slot_valid[wr_ptr] <= 1'b1;
				last_slot          <= wr_ptr;  // also the echo target
				wr_ptr             <= wr_ptr + 1'b1;
				echo_pend          <= 1'b1;
			end
			if (btn_confirm && slot_valid[req_slot]) begin  // empty slot ignored
				btn_pend <= 1'b1;
				btn_slot <= req_slot;
			end
			if (wr_en)
				err_flag <= 1'b0;
			else if (parse_error || gen_error)
				err_flag <= 1'b1;
		end
	end

	assign led = {err_flag, 4'b0000, last_slot, slot_valid};

endmodule

`default_nettype wire

// ==== source/matrix_top.sv ====
/*
 * matrix_top
 * UART receiver feeding the parser and the generator, the
 * two slot store, the printer and the UART transmitter
 */
`default_nettype none

module matrix_top #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] command,      // bit0 input, bit1 generate, bit2 reprint slot
	input  logic       btn_confirm,
	input  logic       uart_rxd,
	output logic       uart_txd,
	output logic [7:0] led
);
	import matrix_pkg::*;

	logic       rx_done, tx_start, tx_busy;
	logic [7:0] rx_data, tx_data;
	logic       input_mode, gen_mode;
	matrix_t    parsed, generated, print_matrix;
	logic       parse_ready, parse_error, gen_ready, gen_error;
	logic       print_start, print_busy, print_done;

	assign input_mode = command[0];
	assign gen_mode   = command[1] & ~command[0];  // input mode wins

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
		.clk, .rst_n, .uart_rxd, .rx_done, .rx_data
	);

	matrix_parser u_parser (
		.clk, .rst_n, .enable(input_mode), .rx_done, .rx_data,
		.parsed, .parse_ready, .parse_error
	);

	matrix_generator u_generator (
		.clk, .rst_n, .enable(gen_mode), .rx_done, .rx_data,
		.generated, .gen_ready, .gen_error
	);

	matrix_store u_store (
		.clk, .rst_n, .parsed, .generated,
		.parse_ready, .gen_ready, .parse_error, .gen_error,
		.btn_confirm, .req_slot(slot_t'(command[2])),
		.print_busy, .print_done, .print_start, .print_matrix, .led
	);

	matrix_printer u_printer (
		.clk, .rst_n, .print_start, .print_matrix, .tx_busy,
		.print_busy, .print_done, .tx_start, .tx_data
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.clk, .rst_n, .tx_start, .tx_data, .uart_txd, .tx_busy
	);

endmodule

`default_nettype wire

// ==== uart/uart_rx.sv ====
/*
 * uart_rx
 * 8N1 serial receiver, samples each bit at its middle
 * and strobes rx_done with the byte in the stop bit
 */
`default_nettype none

module uart_rx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       uart_rxd,
	output logic       rx_done,
	output logic [7:0] rx_data
);
	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {R_IDLE, R_START, R_DATA, R_STOP} rx_state_t;

	rx_state_t        state;
	logic [1:0]       sync;     // two flop synchronizer, line idles high
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= R_IDLE;
			sync    <= 2'b11;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_done <= 1'b0;
			rx_data <= '0;
		end else begin
			sync    <= {sync[0], uart_rxd};
			rx_done <= 1'b0;
			case (state)
				R_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (!sync[1])
						state <= R_START;  // falling edge seen
				end
				R_START: begin
					if (clk_cnt == HALF) begin
						clk_cnt <= '0;
						state   <= sync[1] ? R_IDLE : R_DATA;  // glitch goes back to idle
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				R_DATA: begin
					if (clk_cnt == LAST) begin
						clk_cnt <= '0;
						rx_data <= {sync[1], rx_data[7:1]};  // lsb first
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= R_STOP;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: begin  // R_STOP
					if (clk_cnt == LAST) begin
						rx_done <= sync[1];  // framing error drops the byte
						state   <= R_IDLE;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
/*
 * uart_tx
 * 8N1 serial transmitter, start bit, eight data bits lsb first,
 * stop bit, busy from the cycle after tx_start to the end of stop
 */
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       uart_txd,
	output logic       tx_busy
);
	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);

	logic [9:0]       shifter;  // stop, data, start framed together
	logic [3:0]       bit_cnt;
	logic [CNT_W-1:0] clk_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shifter <= '1;  // line idles high
			bit_cnt <= '0;
			clk_cnt <= '0;
			tx_busy <= 1'b0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				shifter <= {1'b1, tx_data, 1'b0};
				bit_cnt <= '0;
				clk_cnt <= '0;
				tx_busy <= 1'b1;
			end
		end else if (clk_cnt == LAST) begin
			clk_cnt <= '0;
			shifter <= {1'b1, shifter[9:1]};  // fill with idle level
			if (bit_cnt == 4'd9)
				tx_busy <= 1'b0;  // stop bit finished
			else
				bit_cnt <= bit_cnt + 1'b1;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	assign uart_txd = shifter[0];

endmodule

`default_nettype wire

// ==== verification/matrix_assertions.sv ====
/*
 * matrix_assertions
 * strobe checks bound into the store and the printer
 * a request strobe never meets a busy taker, entry paths never collide
 */
`default_nettype none

module matrix_assertions (
	input logic clk,
	input logic rst_n,
	input logic start,    // one cycle request strobe
	input logic busy,     // busy level of the block that takes it
	input logic ready_a,
	input logic ready_b
);
	int unsigned failures = 0;  // read by the testbench

	start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!(start && busy))
	else begin
		$error("start strobe while busy is high");
		failures++;
	end

	// parser and generator run in exclusive modes
	ready_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(ready_a && ready_b))
	else begin
		$error("parse_ready and gen_ready in the same cycle");
		failures++;
	end

endmodule

// ========================================
// bindings
// ========================================
bind matrix_store matrix_assertions u_store_checks (
	.clk, .rst_n, .start(print_start), .busy(print_busy),
	.ready_a(parse_ready), .ready_b(gen_ready)
);

bind matrix_printer matrix_assertions u_printer_checks (
	.clk, .rst_n, .start(tx_start), .busy(tx_busy),
	.ready_a(1'b0), .ready_b(1'b0)  // no entry paths here
);

`default_nettype wire

// ==== verification/tb_matrix_top.sv ====
/*
 * tb_matrix_top
 * drives matrix_top over its UART at 8 clocks per bit, decodes
 * uart_txd and compares every printed byte with a reference model
 */
`default_nettype none

module tb_matrix_top;

	logic       clk;
	logic       rst_n;
	logic [7:0] command;
	logic       btn_confirm;
	logic       uart_rxd;
	logic       uart_txd;
	logic [7:0] led;

	logic [7:0]   exp_q[$];          // expected tx bytes in order
	logic [7:0]   got_q[$];          // decoded tx bytes
	int           tx_bytes_seen = 0;
	int           budget_bytes = 0;  // bytes sent plus bytes expected
	int           cycles = 0;
	int           k;

	// slot model
	int           ref_rows [2];
	int           ref_cols [2];
	logic [199:0] ref_elems [2];
	logic [1:0]   ref_valid;
	logic         ref_wr;
	logic         ref_last;
	logic [15:0]  lfsr_model;  // generator LFSR copy

	initial clk = 1'b0;
	always #5 clk = ~clk;

	matrix_top #(.CLKS_PER_BIT(8)) u_dut (
		.clk, .rst_n, .command, .btn_confirm, .uart_rxd, .uart_txd, .led
	);

	// ========================================
	// reference model
	// ========================================
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // shift left, taps 15 13 12 10
	endfunction

	function automatic logic [7:0] led_expected();
		return {1'b0, 4'b0000, ref_last, ref_valid};  // error flag clear after a store
	endfunction

	// digits, space between, CR LF after the last of a row
	function automatic void format_matrix(input int rows, input int cols,
	                                      input logic [199:0] elems);
		int r;
		int c;
		for (r = 0; r < rows; r++) begin
			for (c = 0; c < cols; c++) begin
				exp_q.push_back(8'h30 + elems[8*(r*cols+c) +: 8]);
				if (c == cols - 1) begin
					exp_q.push_back(8'h0D);
					exp_q.push_back(8'h0A);
					budget_bytes += 3;
				end else begin
					exp_q.push_back(8'h20);
					budget_bytes += 2;
				end
			end
		end
	endfunction

	// echo expected, slot written at the pointer
	task automatic record_store(input int rows, input int cols, input logic [199:0] elems);
		format_matrix(rows, cols, elems);
		ref_rows[ref_wr]  = rows;
		ref_cols[ref_wr]  = cols;
		ref_elems[ref_wr] = elems;
		ref_valid[ref_wr] = 1'b1;
		ref_last          = ref_wr;
		ref_wr            = ~ref_wr;
	endtask

	// ========================================
	// checking
	// ========================================
	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got,
	                     input logic [31:0] expected);
		if (got !== expected) begin
			$display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
			         $time, name, got, expected);
			fail_run();
		end
	endtask

	// limit is 12 bits of 8 clocks per byte plus margin
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > budget_bytes * 96 + 4000) begin
			$display("timeout: the run did not finish within %0d cycles", cycles);
			fail_run();
		end
		if (u_dut.u_store.u_store_checks.failures +
		    u_dut.u_printer.u_printer_checks.failures != 0) begin
			$display("an assertion in the DUT failed at %0t", $time);
			fail_run();
		end
	end

	// uart_txd decoder, sampled on the falling edge
	initial begin : tx_monitor
		logic [7:0] b;
		int         i;
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1 && uart_txd === 1'b0) begin
				repeat (4) @(negedge clk);  // middle of start bit
				for (i = 0; i < 8; i++) begin
					repeat (8) @(negedge clk);
					b[i] = uart_txd;  // lsb first
				end
				repeat (8) @(negedge clk);
				check("uart_txd stop bit", 32'(uart_txd), 32'd1);
				got_q.push_back(b);
				tx_bytes_seen++;
			end
		end
	end

	initial begin : compare
		logic [7:0] got;
		forever begin
			@(negedge clk);
			while (got_q.size() > 0) begin
				got = got_q.pop_front();
				if (exp_q.size() == 0) begin
					$display("unexpected byte 0x%0h on uart_txd at %0t", got, $time);
					fail_run();
				end else
					check("uart_txd byte", 32'(got), 32'(exp_q.pop_front()));
			end
		end
	end

	// ========================================
	// stimulus, all on the falling edge
	// ========================================
	task automatic send_byte(input logic [7:0] b);
		int i;
		int gap;
		budget_bytes++;
		uart_rxd = 1'b0;  // start bit
		repeat (8) @(negedge clk);
		for (i = 0; i < 8; i++) begin
			uart_rxd = b[i];
			repeat (8) @(negedge clk);
		end
		uart_rxd = 1'b1;  // stop bit
		repeat (8) @(negedge clk);
		gap = $urandom_range(12);
		repeat (gap) @(negedge clk);
	endtask

	task automatic send_sep();
		case ($urandom_range(2))
			0: send_byte(8'h20);
			1: begin
				send_byte(8'h0D);
				send_byte(8'h0A);
			end
			default: send_byte(8'h0A);
		endcase
	endtask

	// drain expected bytes, then led
	task automatic finish_print();
		while (exp_q.size() != 0)
			@(negedge clk);
		check("led", 32'(led), 32'(led_expected()));
	endtask

	task automatic press_button(input int slot);
		command     = {5'b00000, slot[0], 2'b00};
		btn_confirm = 1'b1;
		@(negedge clk);
		btn_confirm = 1'b0;
	endtask

	task automatic reprint(input int slot);
		format_matrix(ref_rows[slot], ref_cols[slot], ref_elems[slot]);
		press_button(slot);
		finish_print();
	endtask

	task automatic enter_matrix();
		int           rows;
		int           cols;
		int           i;
		logic [199:0] elems;
		rows  = $urandom_range(5, 1);
		cols  = $urandom_range(5, 1);
		elems = '0;
		for (i = 0; i < rows * cols; i++)
			elems[8*i +: 8] = 8'($urandom_range(9));
		command = 8'h01;  // input mode
		@(negedge clk);
		record_store(rows, cols, elems);
		send_byte(8'h30 + 8'(rows));
		send_sep();
		send_byte(8'h30 + 8'(cols));
		send_sep();
		for (i = 0; i < rows * cols; i++) begin
			send_byte(8'h30 + elems[8*i +: 8]);
			send_sep();
		end
		finish_print();
	endtask

	task automatic generate_matrix();
		int           rows;
		int           cols;
		int           i;
		logic [199:0] elems;
		rows  = $urandom_range(5, 1);
		cols  = $urandom_range(5, 1);
		elems = '0;
		for (i = 0; i < rows * cols; i++) begin
			lfsr_model      = lfsr_step(lfsr_model);  // step, then low byte mod 10
			elems[8*i +: 8] = lfsr_model[7:0] % 8'd10;
		end
		command = 8'h02;  // generate mode
		@(negedge clk);
		record_store(rows, cols, elems);
		send_byte(8'h30 + 8'(rows));
		send_byte(8'h30 + 8'(cols));
		finish_print();
	endtask

	// rows 0, rows 7, or a letter among the elements
	task automatic send_bad_entry(input int kind);
		int seen_before;
		seen_before = tx_bytes_seen;
		command     = 8'h01;
		@(negedge clk);
		case (kind)
			0: send_byte(8'h30);
			1: send_byte(8'h37);
			default: begin
				send_byte(8'h32);
				send_byte(8'h20);
				send_byte(8'h32);
				send_byte(8'h20);
				send_byte(8'h33);
				send_byte(8'h61);  // letter a
			end
		endcase
		while (led[7] !== 1'b1)
			@(negedge clk);
		repeat (150) @(negedge clk);  // window for a stray print
		check("tx bytes after bad entry", 32'(tx_bytes_seen), 32'(seen_before));
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial begin
		void'($urandom(32'hb12f_7166));
		rst_n       = 1'b0;
		command     = 8'h00;
		btn_confirm = 1'b0;
		uart_rxd    = 1'b1;  // line idle
		ref_valid   = 2'b00;
		ref_wr      = 1'b0;
		ref_last    = 1'b0;
		lfsr_model  = 16'hACE1;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// empty slots right after reset
		press_button(0);
		press_button(1);
		repeat (300) @(negedge clk);
		check("tx bytes after empty slot request", 32'(tx_bytes_seen), 32'd0);
		check("led", 32'(led), 32'd0);

		enter_matrix();     // slot 0
		generate_matrix();  // slot 1
		reprint(0);
		reprint(1);
		generate_matrix();  // overwrites slot 0, LFSR carries on
		reprint(0);

		for (k = 0; k < 3; k++) begin
			send_bad_entry(k);
			enter_matrix();  // clears the error flag
		end

		if (exp_q.size() == 0 && got_q.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("bytes left over at the end of the run");
			fail_run();
		end
	end

endmodule

`default_nettype wire
